/* sources.f */
logic/scaler_pkg.sv
logic/booth_multiplier.sv
logic/sample_capture.sv
logic/scaler_core.sv
logic/channel_select_sat.sv
logic/channel_scaler_top.sv
testbench/channel_scaler_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scaler testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module channel_scaler_tb -o channel_scaler_sim \
    && ./obj_dir/channel_scaler_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/channel_scaler_tb.sv */
/* Testbench for the four-channel scaler, with directed and random stimulus,
   a reference model with its own gain copy, an in-order result checker and a timeout */

`timescale 1ns/1ps

module channel_scaler_tb;

    localparam int out_w      = 8;
    localparam int latency    = 3;
    // Longest run is about 1200 cycles with the widest random gaps
    localparam int max_cycles = 2000;

    // One expected result tagged with the cycle of its strobe
    typedef struct packed {
        int                      tag;
        logic                    ovf;
        logic signed [out_w-1:0] data;
    } expect_t;

    logic                                         clk;
    logic                                         arst_n;
    logic                                         in_strobe;
    scaler_pkg::sample_t [scaler_pkg::num_ch-1:0] in_samples;
    scaler_pkg::chan_sel_t                        in_sel;
    logic                                         gain_wr;
    scaler_pkg::chan_sel_t                        gain_idx;
    scaler_pkg::gain_t                            gain_value;
    logic                                         out_valid;
    logic signed [out_w-1:0]                      out_data;
    logic                                         out_ovf;

    // Model state
    scaler_pkg::gain_t [scaler_pkg::num_ch-1:0] model_gain;
    expect_t exp_q[$];
    int      cycle_cnt;
    int      data_errs;
    int      ovf_errs;
    int      lat_errs;
    int      proto_errs;

    channel_scaler_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_strobe (in_strobe),
        .in_samples(in_samples),
        .in_sel    (in_sel),
        .gain_wr   (gain_wr),
        .gain_idx  (gain_idx),
        .gain_value(gain_value),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ovf   (out_ovf)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Selected sample times its gain clamped to the signed out_w range
    function automatic logic [out_w:0] ref_scale(
        input scaler_pkg::sample_t [scaler_pkg::num_ch-1:0] samples,
        input scaler_pkg::gain_t   [scaler_pkg::num_ch-1:0] gains,
        input scaler_pkg::chan_sel_t                        sel
    );
        int prod;
        int hi;
        int lo;
        hi   = (1 << (out_w - 1)) - 1;
        lo   = -(1 << (out_w - 1));
        prod = int'(samples[sel]) * int'(gains[sel]);
        if (prod > hi) begin
            return {1'b1, hi[out_w-1:0]};
        end else if (prod < lo) begin
            return {1'b1, lo[out_w-1:0]};
        end
        return {1'b0, prod[out_w-1:0]};
    endfunction

    // Closing line with the error counts
    task automatic print_counts();
        $display("Errors: data=%0d ovf=%0d latency=%0d protocol=%0d",
                 data_errs, ovf_errs, lat_errs, proto_errs);
    endtask

    // Reads the inputs the DUT samples at this edge before the stimulus NBAs land
    always @(posedge clk) begin : model_blk
        logic [out_w:0] r;
        expect_t        e;
        if (in_strobe) begin
            r      = ref_scale(in_samples, model_gain, in_sel);
            e.tag  = cycle_cnt;
            e.ovf  = r[out_w];
            e.data = r[out_w-1:0];
            exp_q.push_back(e);
        end
        // Gain update follows the lookup so a same-cycle strobe keeps the old gain
        if (gain_wr) begin
            model_gain[gain_idx] = gain_value;
        end
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("ERROR: timeout, run stopped after %0d cycles", cycle_cnt);
            print_counts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : check_blk
        expect_t e;
        if (exp_q.size() > 0 && cycle_cnt - exp_q[0].tag > latency) begin
            $display("ERROR at %0t: no out_valid for the strobe of cycle %0d",
                     $time, exp_q[0].tag);
            proto_errs++;
            e = exp_q.pop_front();
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: out_valid high with no strobe pending", $time);
                proto_errs++;
            end else begin
                e = exp_q.pop_front();
                assert (cycle_cnt - e.tag == latency) else begin
                    $display("CHECK FAILED time=%0t out_valid latency expected=%0d actual=%0d",
                             $time, latency, cycle_cnt - e.tag);
                    lat_errs++;
                end
                assert (out_data == e.data) else begin
                    $display("CHECK FAILED time=%0t out_data expected=%0d actual=%0d",
                             $time, e.data, out_data);
                    data_errs++;
                end
                assert (out_ovf == e.ovf) else begin
                    $display("CHECK FAILED time=%0t out_ovf expected=%0b actual=%0b",
                             $time, e.ovf, out_ovf);
                    ovf_errs++;
                end
            end
        end
    end

    // One clock of stimulus
    task automatic drive_cycle(
        input logic                                         strobe,
        input scaler_pkg::sample_t [scaler_pkg::num_ch-1:0] samples,
        input scaler_pkg::chan_sel_t                        sel,
        input logic                                         wr,
        input scaler_pkg::chan_sel_t                        idx,
        input scaler_pkg::gain_t                            val
    );
        @(posedge clk);
        in_strobe  <= strobe;
        in_samples <= samples;
        in_sel     <= sel;
        gain_wr    <= wr;
        gain_idx   <= idx;
        gain_value <= val;
    endtask

    task automatic send_set(input scaler_pkg::sample_t [3:0] samples,
                            input scaler_pkg::chan_sel_t sel);
        drive_cycle(1'b1, samples, sel, 1'b0, 2'd0, 8'sd0);
    endtask

    task automatic write_gain(input scaler_pkg::chan_sel_t idx, input scaler_pkg::gain_t val);
        drive_cycle(1'b0, '0, 2'd0, 1'b1, idx, val);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 2'd0, 1'b0, 2'd0, 8'sd0);
    endtask

    initial begin : stim_blk
        scaler_pkg::sample_t [3:0] set_a;
        scaler_pkg::sample_t [3:0] set_b;
        scaler_pkg::sample_t [3:0] set_c;
        void'($urandom(92));
        set_a      = {-8'sd90, 8'sd45, -8'sd3, 8'sd117};
        set_b      = {8'sd20, -8'sd25, 8'sd60, 8'sd30};
        set_c      = {8'sd100, 8'h80, 8'sd127, 8'h80};
        model_gain = {4{8'sd1}};
        cycle_cnt  = 0;
        data_errs  = 0;
        ovf_errs   = 0;
        lat_errs   = 0;
        proto_errs = 0;
        arst_n     = 1'b0;
        in_strobe  = 1'b0;
        in_samples = '0;
        in_sel     = 2'd0;
        gain_wr    = 1'b0;
        gain_idx   = 2'd0;
        gain_value = 8'sd0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Quiet after reset and then identity gains
        repeat (5) begin
            idle(1);
            @(negedge clk);
            assert (!out_valid) else begin
                $display("CHECK FAILED time=%0t out_valid expected=0 actual=%0b",
                         $time, out_valid);
                proto_errs++;
            end
            assert (!out_ovf) else begin
                $display("CHECK FAILED time=%0t out_ovf expected=0 actual=%0b",
                         $time, out_ovf);
                ovf_errs++;
            end
        end
        for (int s = 0; s < 4; s++) send_set(set_a, scaler_pkg::chan_sel_t'(s));

        // Positive, negative and zero gains
        write_gain(2'd0, 8'sd3);
        write_gain(2'd1, -8'sd2);
        write_gain(2'd2, 8'sd0);
        write_gain(2'd3, -8'sd1);
        for (int s = 0; s < 4; s++) send_set(set_b, scaler_pkg::chan_sel_t'(s));
        // Write then strobe on the next cycle
        write_gain(2'd0, -8'sd4);
        send_set(set_b, 2'd0);
        // Write and strobe together so the old gain applies
        drive_cycle(1'b1, set_b, 2'd1, 1'b1, 2'd1, 8'sd5);
        send_set(set_b, 2'd1);
        idle(4);

        // Saturation corners
        write_gain(2'd0, 8'h80);
        write_gain(2'd1, 8'sd127);
        write_gain(2'd2, 8'sd127);
        write_gain(2'd3, 8'sd1);
        for (int s = 0; s < 4; s++) send_set(set_c, scaler_pkg::chan_sel_t'(s));
        idle(4);

        // Back to back with interleaved gain writes
        for (int i = 0; i < 200; i++) begin
            drive_cycle(1'b1, $urandom(), scaler_pkg::chan_sel_t'($urandom_range(3)),
                        $urandom_range(3) == 0, scaler_pkg::chan_sel_t'($urandom_range(3)),
                        scaler_pkg::gain_t'($urandom()));
        end
        idle(4);

        // Sparse traffic with random gaps
        for (int i = 0; i < 300; i++) begin
            repeat ($urandom_range(2)) begin
                drive_cycle(1'b0, '0, 2'd0, $urandom_range(3) == 0,
                            scaler_pkg::chan_sel_t'($urandom_range(3)),
                            scaler_pkg::gain_t'($urandom()));
            end
            send_set($urandom(), scaler_pkg::chan_sel_t'($urandom_range(3)));
        end
        idle(8);

        if (exp_q.size() != 0) begin
            $display("ERROR: %0d results never arrived", exp_q.size());
            proto_errs += exp_q.size();
        end
        print_counts();
        if (data_errs + ovf_errs + lat_errs + proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* logic/channel_scaler_top.sv */
/* Four-channel sample scaler top, capture to Booth core
   to select and saturate, three cycles in all */

`timescale 1ns/1ps

module channel_scaler_top #(
    parameter int op_w  = 8,
    parameter int out_w = 8
) (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         in_strobe,
    input  scaler_pkg::sample_t [scaler_pkg::num_ch-1:0] in_samples,
    input  scaler_pkg::chan_sel_t                        in_sel,
    input  logic                                         gain_wr,
    input  scaler_pkg::chan_sel_t                        gain_idx,
    input  scaler_pkg::gain_t                            gain_value,
    output logic                                         out_valid,
    output logic signed [out_w-1:0]                      out_data,
    output logic                                         out_ovf
);

    // Stage links
    scaler_pkg::sample_set_t  sample_set;
    scaler_pkg::gain_set_t    gain_set;
    scaler_pkg::product_set_t product_set;

    // Cycle 1, samples and gain snapshot
    sample_capture u_capture (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_strobe (in_strobe),
        .in_samples(in_samples),
        .in_sel    (in_sel),
        .gain_wr   (gain_wr),
        .gain_idx  (gain_idx),
        .gain_value(gain_value),
        .sample_set(sample_set),
        .gain_set  (gain_set)
    );

    // Cycle 2, multiply all channels
    scaler_core #(
        .op_w(op_w)
    ) u_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .sample_set (sample_set),
        .gain_set   (gain_set),
        .product_set(product_set)
    );

    // Cycle 3, pick and clamp
    channel_select_sat #(
        .out_w(out_w)
    ) u_out (
        .clk        (clk),
        .arst_n     (arst_n),
        .product_set(product_set),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ovf    (out_ovf)
    );

endmodule

/* logic/channel_select_sat.sv */
/* Output stage, channel pick, signed saturation to out_w bits,
   registered data with strobe and overflow flag */

`timescale 1ns/1ps

module channel_select_sat #(
    parameter int out_w = 8
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  scaler_pkg::product_set_t product_set,
    output logic                     out_valid,
    output logic signed [out_w-1:0]  out_data,
    output logic                     out_ovf
);

    // Signed limits of the output width in product width
    localparam scaler_pkg::product_t sat_max = scaler_pkg::product_t'((1 <<< (out_w - 1)) - 1);
    localparam scaler_pkg::product_t sat_min = scaler_pkg::product_t'(-(1 <<< (out_w - 1)));

    scaler_pkg::product_t    picked;
    scaler_pkg::product_t    clipped;
    logic                    ovf;
    logic signed [out_w-1:0] sat_data;

    // Channel mux
    always_comb begin
        case (product_set.sel)
            2'd0:    picked = product_set.ch0;
            2'd1:    picked = product_set.ch1;
            2'd2:    picked = product_set.ch2;
            default: picked = product_set.ch3;
        endcase
    end

    // Clamp to the nearer limit and flag the clipping
    always_comb begin
        clipped = picked;
        ovf     = 1'b0;
        if (picked > sat_max) begin
            clipped = sat_max;
            ovf     = 1'b1;
        end else if (picked < sat_min) begin
            clipped = sat_min;
            ovf     = 1'b1;
        end
    end

    // After clamping the low out_w bits hold the whole value
    assign sat_data = clipped[out_w-1:0];

    // Data and flag hold between results
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            out_ovf   <= 1'b0;
        end else begin
            out_valid <= product_set.valid;
            if (product_set.valid) begin
                out_data <= sat_data;
                out_ovf  <= ovf;
            end
        end
    end

    // Every result leaves with a resolved flag and data
    a_result_known: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown({out_ovf, out_data}));

endmodule

/* logic/scaler_core.sv */
/* Processing stage, four Booth multipliers with the products
   registered alongside the select and valid */

`timescale 1ns/1ps

module scaler_core #(
    parameter int op_w = 8
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  scaler_pkg::sample_set_t  sample_set,
    input  scaler_pkg::gain_set_t    gain_set,
    output scaler_pkg::product_set_t product_set
);

    // Per-channel operand views of the incoming structs
    scaler_pkg::sample_t samples [scaler_pkg::num_ch];
    scaler_pkg::gain_t   gains   [scaler_pkg::num_ch];

    // Combinational products, straight from the multipliers
    logic signed [2*op_w-1:0] prod [scaler_pkg::num_ch];

    // Registered stage outputs
    scaler_pkg::product_t  prod_q [scaler_pkg::num_ch];
    scaler_pkg::chan_sel_t sel_q;
    logic                  valid_q;

    assign samples[0] = sample_set.ch0;
    assign samples[1] = sample_set.ch1;
    assign samples[2] = sample_set.ch2;
    assign samples[3] = sample_set.ch3;

    assign gains[0] = gain_set.ch0;
    assign gains[1] = gain_set.ch1;
    assign gains[2] = gain_set.ch2;
    assign gains[3] = gain_set.ch3;

    // One multiplier per channel, sample times its gain
    for (genvar c = 0; c < scaler_pkg::num_ch; c++) begin : g_mult
        booth_multiplier #(
            .op_w(op_w)
        ) u_mult (
            .multiplicand(samples[c]),
            .multiplier  (gains[c]),
            .product     (prod[c])
        );
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample_set.valid;
        end
    end

    // Loaded every cycle so sets can follow each other without gaps
    always_ff @(posedge clk) begin
        sel_q <= sample_set.sel;
        for (int i = 0; i < scaler_pkg::num_ch; i++) begin
            prod_q[i] <= prod[i];
        end
    end

    assign product_set = '{valid: valid_q, sel: sel_q,
                           ch3: prod_q[3], ch2: prod_q[2],
                           ch1: prod_q[1], ch0: prod_q[0]};

    // Valid must resolve once capture is out of reset
    a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(valid_q));

endmodule

/* logic/sample_capture.sv */
/* Input stage with the four channel gain registers and the
   sample set register loaded on each input strobe */

`timescale 1ns/1ps

module sample_capture (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         in_strobe,
    input  scaler_pkg::sample_t [scaler_pkg::num_ch-1:0] in_samples,
    input  scaler_pkg::chan_sel_t                        in_sel,
    input  logic                                         gain_wr,
    input  scaler_pkg::chan_sel_t                        gain_idx,
    input  scaler_pkg::gain_t                            gain_value,
    output scaler_pkg::sample_set_t                      sample_set,
    output scaler_pkg::gain_set_t                        gain_set
);

    // Live gain registers, written through gain_wr
    scaler_pkg::gain_t gain_q [scaler_pkg::num_ch];

    // Sample set payload and its strobe
    scaler_pkg::sample_t [scaler_pkg::num_ch-1:0] samples_q;
    scaler_pkg::chan_sel_t                        sel_q;
    logic                                         valid_q;

    // Gains frozen with the samples, so a later write cannot reach them
    scaler_pkg::gain_set_t gain_snap_q;

    // Gains come out of reset as one, the identity scale
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < scaler_pkg::num_ch; i++) begin
                gain_q[i] <= scaler_pkg::gain_t'(1);
            end
        end else if (gain_wr) begin
            gain_q[gain_idx] <= gain_value;
        end
    end

    // Valid tracks the strobe every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_strobe;
        end
    end

    // Samples, select and gain snapshot load together on the strobe
    // A write in the same cycle is not yet visible in gain_q
    always_ff @(posedge clk) begin
        if (in_strobe) begin
            samples_q   <= in_samples;
            sel_q       <= in_sel;
            gain_snap_q <= '{ch3: gain_q[3], ch2: gain_q[2], ch1: gain_q[1], ch0: gain_q[0]};
        end
    end

    assign sample_set = '{valid: valid_q, sel: sel_q,
                          ch3: samples_q[3], ch2: samples_q[2],
                          ch1: samples_q[1], ch0: samples_q[0]};
    assign gain_set   = gain_snap_q;

    // Indices must be clean whenever their strobe is taken
    a_sel_known: assert property (@(posedge clk) disable iff (!arst_n)
        in_strobe |-> !$isunknown(in_sel));
    a_gain_idx_known: assert property (@(posedge clk) disable iff (!arst_n)
        gain_wr |-> !$isunknown(gain_idx));

endmodule

/* logic/booth_multiplier.sv */
/* Combinational radix-2 Booth multiplier, signed operands,
   full double-width signed product */

`timescale 1ns/1ps

module booth_multiplier #(
    parameter int op_w = 8
) (
    input  logic signed [op_w-1:0]   multiplicand,
    input  logic signed [op_w-1:0]   multiplier,
    output logic signed [2*op_w-1:0] product
);

    // Multiplicand sign-extended to the product width
    logic signed [2*op_w-1:0] mcand_ext;

    // Multiplier with the implicit zero below bit 0
    logic [op_w:0] mplier_ext;

    // Running partial sum
    logic signed [2*op_w-1:0] accum;

    assign mcand_ext  = {{op_w{multiplicand[op_w-1]}}, multiplicand};
    assign mplier_ext = {multiplier, 1'b0};

    // Scan each bit pair, low to high
    // 01 ends a run of ones, add; 10 starts one, subtract
    always_comb begin
        accum = '0;
        for (int i = 0; i < op_w; i++) begin
            case (mplier_ext[i +: 2])
                2'b01: begin
                    accum = accum + (mcand_ext <<< i);
                end
                2'b10: begin
                    accum = accum - (mcand_ext <<< i);
                end
                default: begin
                    accum = accum;
                end
            endcase
        end
    end

    // The whole product, the top pair of the multiplier carries its sign
    assign product = accum;

endmodule

/* logic/scaler_pkg.sv */
/* Shared channel count, sample, gain and product types,
   and the packed structs passed between the scaler stages */

package scaler_pkg;

    // Four channels, picked by a two-bit select
    localparam int num_ch = 4;

    // Signed input sample
    typedef logic signed [7:0] sample_t;

    // Signed per-channel gain
    typedef logic signed [7:0] gain_t;

    // Full signed sample times gain, no truncation
    typedef logic signed [15:0] product_t;

    // Channel index, used for output select and gain write index
    typedef logic [1:0] chan_sel_t;

    // Captured sample set, capture to core (35 bits)
    typedef struct packed {
        logic      valid;
        chan_sel_t sel;
        sample_t   ch3;
        sample_t   ch2;
        sample_t   ch1;
        sample_t   ch0;
    } sample_set_t;

    // Gains bound to one sample set (32 bits)
    typedef struct packed {
        gain_t ch3;
        gain_t ch2;
        gain_t ch1;
        gain_t ch0;
    } gain_set_t;

    // Registered products, core to output side (67 bits)
    typedef struct packed {
        logic      valid;
        chan_sel_t sel;
        product_t  ch3;
        product_t  ch2;
        product_t  ch1;
        product_t  ch0;
    } product_set_t;

endpackage
